// ==== cpu_core.f ====
+incdir+.
isa_pkg.sv
pipeline_types.sv
regfile_if.sv
regfile.sv
pc.sv
alu.sv
branch_unit.sv
lsu.sv
id.sv
cpu_core.sv
tb_cpu_core.sv

// ==== tb_cpu_core.sv ====
`timescale 1ns/1ps
`include "cpu_cfg.svh"

module tb_cpu_core;

    localparam int ROM_WORDS = 512;

    logic        clk;
    logic        rst_i;
    logic [31:0] rom_inst_i;
    logic        inst_en_o;
    logic [31:0] pc_o;
    logic        cache_hit_i;
    logic [31:0] ram_read_data_i;
    logic [31:0] ram_addr_o;
    logic [31:0] ram_write_data_o;
    logic        ram_write_en_o;
    logic        ram_read_en_o;
    logic [3:0]  ram_select_o;
    logic        ram_en_o;

    logic [31:0] rom [ROM_WORDS];
    logic [31:0] ram [256];
    logic [31:0] ram_init [256];
    logic [31:0] rom_off;
    int          prog_len;

    // expected memory accesses from the ISA model
    logic [31:0] exp_addr [$];
    logic [31:0] exp_data [$];
    logic [3:0]  exp_sel [$];
    logic        exp_write [$];

    int          error_count;
    int          cycle_count;
    int          cycle_limit;
    int          hit_wait;
    logic        all_accesses_seen;
    logic        held_valid;
    logic [31:0] held_addr;
    logic [31:0] held_data;
    logic [3:0]  held_sel;

    cpu_core i_cpu_core (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    assign rom_off         = pc_o - `CPU_RESET_PC;
    assign rom_inst_i      = (rom_off < ROM_WORDS * 4) ? rom[rom_off[10:2]] : 32'd0;
    assign ram_read_data_i = ram[ram_addr_o[9:2]];

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            error_count++;
            $display("Mismatch %s expected %h actual %h", name, expected, actual);
            $display("Result: FAILED");
            $fatal(1, "stopping at first error");
        end
    endtask

    function automatic logic [31:0] fill_word(int i);
        return {8'(i), 8'(i) ^ 8'h5a, 8'(255 - i), 8'(i * 7 + 3)};
    endfunction

    function automatic logic [31:0] enc_3r(logic [16:0] op, int rd, int rj, int rk);
        return {op, 5'(rk), 5'(rj), 5'(rd)};
    endfunction

    function automatic logic [31:0] enc_ri12(logic [9:0] op, int rd, int rj, int imm);
        return {op, 12'(imm), 5'(rj), 5'(rd)};
    endfunction

    function automatic logic [31:0] enc_br(logic [5:0] op, int rj, int rd, int offs);
        return {op, 16'(offs), 5'(rj), 5'(rd)};
    endfunction

    function automatic logic [31:0] enc_b(int offs);
        logic [25:0] o;
        o = 26'(offs);
        return {isa_pkg::OP_B, o[15:0], o[25:16]};
    endfunction

    task automatic put_word(input logic [31:0] w);
        rom[prog_len] = w;
        prog_len++;
    endtask

    task automatic build_program();
        logic [16:0] ops3r [6];
        int kind;
        int ra;
        int rb;
        ops3r = '{isa_pkg::OP_ADD_W, isa_pkg::OP_SUB_W, isa_pkg::OP_SLT,
                  isa_pkg::OP_AND, isa_pkg::OP_OR, isa_pkg::OP_XOR};
        for (int r = 1; r < 32; r++) begin
            put_word(enc_ri12(isa_pkg::OP_ADDI_W, r, 0, $urandom % 4096));
        end
        // random alu mix where r0 may be a target
        for (int i = 0; i < 40; i++) begin
            kind = $urandom % 8;
            if (kind < 6) begin
                put_word(enc_3r(ops3r[kind], $urandom % 32, $urandom % 32, $urandom % 32));
            end else if (kind == 6) begin
                put_word(enc_ri12(isa_pkg::OP_ADDI_W, $urandom % 32, $urandom % 32,
                                  $urandom % 4096));
            end else begin
                put_word({isa_pkg::OP_LU12I_W, 20'($urandom), 5'($urandom % 32)});
            end
        end
        for (int r = 0; r < 32; r++) begin
            put_word(enc_ri12(isa_pkg::OP_ST_W, r, 0, 4 * r));
        end
        // load/store round trips
        for (int i = 0; i < 10; i++) begin
            ra = 1 + $urandom % 31;
            rb = 1 + $urandom % 31;
            put_word(enc_ri12(isa_pkg::OP_LD_W, ra, 0, 4 * ($urandom % 48)));
            put_word(enc_3r(isa_pkg::OP_ADD_W, rb, ra, rb));
            put_word(enc_ri12(isa_pkg::OP_ST_W, ra, 0, 4 * (128 + i)));
            put_word(enc_ri12(isa_pkg::OP_ST_W, rb, 0, 4 * (160 + i)));
        end
        // byte lanes and a read of the merged word
        for (int b = 0; b < 4; b++) begin
            put_word(enc_ri12(isa_pkg::OP_ADDI_W, 5, 0, $urandom % 4096));
            put_word(enc_ri12(isa_pkg::OP_ST_B, 5, 0, 800 + b));
        end
        put_word(enc_ri12(isa_pkg::OP_LD_W, 6, 0, 800));
        put_word(enc_ri12(isa_pkg::OP_ST_W, 6, 0, 804));
        // r10 counts up to r11 with an extra store when r10 equals r13
        put_word(enc_ri12(isa_pkg::OP_ADDI_W, 10, 0, 0));
        put_word(enc_ri12(isa_pkg::OP_ADDI_W, 11, 0, 5));
        put_word(enc_ri12(isa_pkg::OP_ADDI_W, 12, 0, 864));
        put_word(enc_ri12(isa_pkg::OP_ADDI_W, 13, 0, 3));
        put_word(enc_ri12(isa_pkg::OP_ADDI_W, 10, 10, 1));
        put_word(enc_ri12(isa_pkg::OP_ST_W, 10, 12, 0));
        put_word(enc_ri12(isa_pkg::OP_ADDI_W, 12, 12, 4));
        put_word(enc_br(isa_pkg::OP_BEQ, 10, 13, 2));
        put_word(enc_b(2));
        put_word(enc_ri12(isa_pkg::OP_ST_W, 10, 0, 920));
        put_word(enc_br(isa_pkg::OP_BNE, 10, 11, -6));
        put_word(enc_ri12(isa_pkg::OP_ST_W, 12, 0, 924));
        put_word(enc_b(0));
    endtask

    // ISA model that fills the expected access list and returns the instruction count
    function automatic int run_isa_model();
        logic [31:0] regs [32];
        logic [31:0] mem [256];
        logic [31:0] pc;
        logic [31:0] inst;
        logic [31:0] next_pc;
        logic [31:0] si12;
        logic [31:0] addr;
        logic [31:0] rom_idx;
        logic [25:0] offs26;
        logic [7:0] byte_val;
        int rd;
        int rj;
        int rk;
        int count;
        logic halted;
        regs = '{default: 32'd0};
        mem = ram_init;
        pc = `CPU_RESET_PC;
        count = 0;
        halted = 1'b0;
        while (!halted && count < 100000) begin
            rom_idx = (pc - `CPU_RESET_PC) >> 2;
            inst = (rom_idx < ROM_WORDS) ? rom[rom_idx] : 32'd0;
            count++;
            next_pc = pc + 4;
            rd = inst[4:0];
            rj = inst[9:5];
            rk = inst[14:10];
            si12 = {{20{inst[21]}}, inst[21:10]};
            addr = regs[rj] + si12;
            if (inst[31:15] == isa_pkg::OP_ADD_W) begin
                regs[rd] = regs[rj] + regs[rk];
            end else if (inst[31:15] == isa_pkg::OP_SUB_W) begin
                regs[rd] = regs[rj] - regs[rk];
            end else if (inst[31:15] == isa_pkg::OP_SLT) begin
                regs[rd] = ($signed(regs[rj]) < $signed(regs[rk])) ? 32'd1 : 32'd0;
            end else if (inst[31:15] == isa_pkg::OP_AND) begin
                regs[rd] = regs[rj] & regs[rk];
            end else if (inst[31:15] == isa_pkg::OP_OR) begin
                regs[rd] = regs[rj] | regs[rk];
            end else if (inst[31:15] == isa_pkg::OP_XOR) begin
                regs[rd] = regs[rj] ^ regs[rk];
            end else if (inst[31:22] == isa_pkg::OP_ADDI_W) begin
                regs[rd] = addr;
            end else if (inst[31:22] == isa_pkg::OP_LD_W) begin
                regs[rd] = mem[addr[9:2]];
                exp_addr.push_back(addr);
                exp_data.push_back(32'd0);
                exp_sel.push_back(4'hf);
                exp_write.push_back(1'b0);
            end else if (inst[31:22] == isa_pkg::OP_ST_W) begin
                mem[addr[9:2]] = regs[rd];
                exp_addr.push_back(addr);
                exp_data.push_back(regs[rd]);
                exp_sel.push_back(4'hf);
                exp_write.push_back(1'b1);
            end else if (inst[31:22] == isa_pkg::OP_ST_B) begin
                byte_val = regs[rd][7:0];
                mem[addr[9:2]][8 * addr[1:0] +: 8] = byte_val;
                exp_addr.push_back(addr);
                exp_data.push_back({4{byte_val}});
                exp_sel.push_back(4'b0001 << addr[1:0]);
                exp_write.push_back(1'b1);
            end else if (inst[31:25] == isa_pkg::OP_LU12I_W) begin
                regs[rd] = {inst[24:5], 12'd0};
            end else if (inst[31:26] == isa_pkg::OP_BEQ) begin
                if (regs[rj] == regs[rd]) begin
                    next_pc = pc + {{14{inst[25]}}, inst[25:10], 2'b00};
                end
            end else if (inst[31:26] == isa_pkg::OP_BNE) begin
                if (regs[rj] != regs[rd]) begin
                    next_pc = pc + {{14{inst[25]}}, inst[25:10], 2'b00};
                end
            end else if (inst[31:26] == isa_pkg::OP_B) begin
                offs26 = {inst[9:0], inst[25:10]};
                // b 0 is the end of the program
                halted = (offs26 == 26'd0);
                next_pc = pc + {{4{offs26[25]}}, offs26, 2'b00};
            end
            regs[0] = 32'd0;
            pc = next_pc;
        end
        return count;
    endfunction

    // random hit delay of 0 to 3 cycles per request
    always @(negedge clk) begin
        if (!rst_i && ram_en_o && !cache_hit_i) begin
            if (hit_wait < 0) begin
                hit_wait = $urandom % 4;
            end
            if (hit_wait == 0) begin
                cache_hit_i <= 1'b1;
            end else begin
                hit_wait--;
            end
        end else begin
            cache_hit_i <= 1'b0;
            hit_wait = -1;
        end
    end

    always @(posedge clk) begin
        if (ram_en_o && ram_write_en_o && cache_hit_i) begin
            for (int b = 0; b < 4; b++) begin
                if (ram_select_o[b]) begin
                    ram[ram_addr_o[9:2]][8 * b +: 8] <= ram_write_data_o[8 * b +: 8];
                end
            end
        end
    end

    // request stability and memory access comparison
    always @(posedge clk) begin
        if (!rst_i) begin
            if (held_valid) begin
                check_value("ram_en_o", 32'd1, 32'(ram_en_o));
                check_value("ram_addr_o", held_addr, ram_addr_o);
                check_value("ram_write_data_o", held_data, ram_write_data_o);
                check_value("ram_select_o", 32'(held_sel), 32'(ram_select_o));
            end
            held_valid = ram_en_o && !cache_hit_i;
            held_addr = ram_addr_o;
            held_data = ram_write_data_o;
            held_sel = ram_select_o;
            if (ram_en_o && cache_hit_i) begin
                if (exp_addr.size() == 0) begin
                    $display("Unexpected memory access to address %h after the last expected one",
                             ram_addr_o);
                    $display("Result: FAILED");
                    $fatal(1, "extra access");
                end else begin
                    check_value("ram_write_en_o", 32'(exp_write[0]), 32'(ram_write_en_o));
                    check_value("ram_read_en_o", 32'(!exp_write[0]), 32'(ram_read_en_o));
                    check_value("ram_addr_o", exp_addr[0], ram_addr_o);
                    check_value("ram_select_o", 32'(exp_sel[0]), 32'(ram_select_o));
                    if (exp_write[0]) begin
                        check_value("ram_write_data_o", exp_data[0], ram_write_data_o);
                    end
                    void'(exp_addr.pop_front());
                    void'(exp_data.pop_front());
                    void'(exp_sel.pop_front());
                    void'(exp_write.pop_front());
                    if (exp_addr.size() == 0) begin
                        all_accesses_seen = 1'b1;
                    end
                end
            end
        end
    end

    always @(posedge clk) begin
        if (!rst_i) begin
            cycle_count++;
            if (cycle_count > cycle_limit) begin
                $display("The program never finished within %0d cycles", cycle_limit);
                $display("Result: FAILED");
                $fatal(1, "timeout");
            end
        end
    end

    initial begin
        void'($urandom(67));
        rst_i = 1'b1;
        cache_hit_i = 1'b0;
        hit_wait = -1;
        error_count = 0;
        cycle_count = 0;
        cycle_limit = 1000000;
        all_accesses_seen = 1'b0;
        held_valid = 1'b0;
        prog_len = 0;
        for (int i = 0; i < 256; i++) begin
            ram_init[i] = fill_word(i);
            ram[i] = ram_init[i];
        end
        for (int i = 0; i < ROM_WORDS; i++) begin
            rom[i] = 32'd0;
        end
        build_program();
        cycle_limit = 20 * run_isa_model() + 200;
        repeat (16) begin
            @(negedge clk);
            check_value("pc_o", `CPU_RESET_PC, pc_o);
            check_value("ram_en_o", 32'd0, 32'(ram_en_o));
            check_value("ram_write_en_o", 32'd0, 32'(ram_write_en_o));
            check_value("inst_en_o", 32'd0, 32'(inst_en_o));
        end
        rst_i = 1'b0;
        @(negedge clk);
        check_value("pc_o", `CPU_RESET_PC, pc_o);
        check_value("ram_en_o", 32'd0, 32'(ram_en_o));
        wait (all_accesses_seen);
        @(negedge clk);
        if (error_count == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

// ==== cpu_core.sv ====
`timescale 1ns/1ps

module cpu_core (
    input  logic                   clk,
    input  logic                   rst_i,
    input  pipeline_types::bus32_t rom_inst_i,
    output logic                   inst_en_o,
    output pipeline_types::bus32_t pc_o,
    input  logic                   cache_hit_i,
    input  pipeline_types::bus32_t ram_read_data_i,
    output pipeline_types::bus32_t ram_addr_o,
    output pipeline_types::bus32_t ram_write_data_o,
    output logic                   ram_write_en_o,
    output logic                   ram_read_en_o,
    output logic [3:0]             ram_select_o,
    output logic                   ram_en_o
);

    // fetch to execute
    logic stall, redirect, fetch_valid;
    pipeline_types::bus32_t target, fetch_pc, fetch_inst;

    // writeback
    logic rf_we;
    pipeline_types::reg_addr_t rf_waddr;
    pipeline_types::bus32_t rf_wdata;
    regfile_if rf_bus ();

    // alu and branch operands
    pipeline_types::aluop_t aluop;
    pipeline_types::bus32_t alu_a, alu_b, alu_result;
    pipeline_types::br_kind_t br_kind;
    pipeline_types::bus32_t br_rj, br_rd, br_offset, br_target;
    logic br_taken;

    // memory request
    logic lsu_start, lsu_store, lsu_byte, lsu_done;
    pipeline_types::bus32_t lsu_addr, lsu_data, lsu_load_data;

    pc u_pc (
        .clk,
        .rst_i,
        .stall_i       (stall),
        .redirect_i    (redirect),
        .target_i      (target),
        .rom_inst_i    (rom_inst_i),
        .pc_o          (pc_o),
        .inst_en_o     (inst_en_o),
        .fetch_valid_o (fetch_valid),
        .fetch_pc_o    (fetch_pc),
        .fetch_inst_o  (fetch_inst)
    );

    id u_id (
        .clk,
        .rst_i,
        .fetch_valid_i   (fetch_valid),
        .fetch_pc_i      (fetch_pc),
        .fetch_inst_i    (fetch_inst),
        .rf              (rf_bus.reader),
        .rf_we_o         (rf_we),
        .rf_waddr_o      (rf_waddr),
        .rf_wdata_o      (rf_wdata),
        .aluop_o         (aluop),
        .alu_a_o         (alu_a),
        .alu_b_o         (alu_b),
        .alu_result_i    (alu_result),
        .br_kind_o       (br_kind),
        .br_rj_o         (br_rj),
        .br_rd_o         (br_rd),
        .br_offset_o     (br_offset),
        .br_taken_i      (br_taken),
        .br_target_i     (br_target),
        .lsu_start_o     (lsu_start),
        .lsu_store_o     (lsu_store),
        .lsu_byte_o      (lsu_byte),
        .lsu_addr_o      (lsu_addr),
        .lsu_data_o      (lsu_data),
        .lsu_done_i      (lsu_done),
        .lsu_load_data_i (lsu_load_data),
        .stall_o         (stall),
        .redirect_o      (redirect),
        .target_o        (target)
    );

    regfile u_regfile (
        .clk,
        .rst_i,
        .rd_port (rf_bus.file),
        .we_i    (rf_we),
        .waddr_i (rf_waddr),
        .wdata_i (rf_wdata)
    );

    alu u_alu (
        .aluop_i  (aluop),
        .a_i      (alu_a),
        .b_i      (alu_b),
        .result_o (alu_result)
    );

    branch_unit u_branch_unit (
        .kind_i   (br_kind),
        .pc_i     (fetch_pc),
        .rj_i     (br_rj),
        .rd_i     (br_rd),
        .offset_i (br_offset),
        .taken_o  (br_taken),
        .target_o (br_target)
    );

    lsu u_lsu (
        .clk,
        .rst_i,
        .start_i          (lsu_start),
        .store_i          (lsu_store),
        .byte_i           (lsu_byte),
        .addr_i           (lsu_addr),
        .data_i           (lsu_data),
        .cache_hit_i      (cache_hit_i),
        .ram_read_data_i  (ram_read_data_i),
        .ram_addr_o       (ram_addr_o),
        .ram_write_data_o (ram_write_data_o),
        .ram_write_en_o   (ram_write_en_o),
        .ram_read_en_o    (ram_read_en_o),
        .ram_select_o     (ram_select_o),
        .ram_en_o         (ram_en_o),
        .done_o           (lsu_done),
        .load_data_o      (lsu_load_data)
    );

endmodule

// ==== id.sv ====
`timescale 1ns/1ps
`include "cpu_cfg.svh"

module id (
    input  logic                      clk,
    input  logic                      rst_i,
    input  logic                      fetch_valid_i,
    input  pipeline_types::bus32_t    fetch_pc_i,
    input  pipeline_types::bus32_t    fetch_inst_i,
    regfile_if.reader                 rf,
    output logic                      rf_we_o,
    output pipeline_types::reg_addr_t rf_waddr_o,
    output pipeline_types::bus32_t    rf_wdata_o,
    output pipeline_types::aluop_t    aluop_o,
    output pipeline_types::bus32_t    alu_a_o,
    output pipeline_types::bus32_t    alu_b_o,
    input  pipeline_types::bus32_t    alu_result_i,
    output pipeline_types::br_kind_t  br_kind_o,
    output pipeline_types::bus32_t    br_rj_o,
    output pipeline_types::bus32_t    br_rd_o,
    output pipeline_types::bus32_t    br_offset_o,
    input  logic                      br_taken_i,
    input  pipeline_types::bus32_t    br_target_i,
    output logic                      lsu_start_o,
    output logic                      lsu_store_o,
    output logic                      lsu_byte_o,
    output pipeline_types::bus32_t    lsu_addr_o,
    output pipeline_types::bus32_t    lsu_data_o,
    input  logic                      lsu_done_i,
    input  pipeline_types::bus32_t    lsu_load_data_i,
    output logic                      stall_o,
    output logic                      redirect_o,
    output pipeline_types::bus32_t    target_o
);

    logic [16:0] op17;
    logic [9:0] op10;
    logic [6:0] op7;
    logic [5:0] op6;
    pipeline_types::reg_addr_t rd;
    pipeline_types::reg_addr_t rj;
    pipeline_types::reg_addr_t rk;
    logic is_add, is_sub, is_slt, is_and, is_or, is_xor;
    logic is_addi, is_lu12i, is_ld, is_stw, is_stb;
    logic is_beq, is_bne, is_b;
    logic is_rr;
    logic mem_op;
    logic started_q;

    assign op17 = fetch_inst_i[31:15];
    assign op10 = fetch_inst_i[31:22];
    assign op7  = fetch_inst_i[31:25];
    assign op6  = fetch_inst_i[31:26];
    assign rd   = fetch_inst_i[isa_pkg::RD_LSB +: `CPU_REG_ADDR_W];
    assign rj   = fetch_inst_i[isa_pkg::RJ_LSB +: `CPU_REG_ADDR_W];
    assign rk   = fetch_inst_i[isa_pkg::RK_LSB +: `CPU_REG_ADDR_W];

    // a bubble or unknown word decodes to nothing
    assign is_add   = fetch_valid_i && op17 == isa_pkg::OP_ADD_W;
    assign is_sub   = fetch_valid_i && op17 == isa_pkg::OP_SUB_W;
    assign is_slt   = fetch_valid_i && op17 == isa_pkg::OP_SLT;
    assign is_and   = fetch_valid_i && op17 == isa_pkg::OP_AND;
    assign is_or    = fetch_valid_i && op17 == isa_pkg::OP_OR;
    assign is_xor   = fetch_valid_i && op17 == isa_pkg::OP_XOR;
    assign is_addi  = fetch_valid_i && op10 == isa_pkg::OP_ADDI_W;
    assign is_ld    = fetch_valid_i && op10 == isa_pkg::OP_LD_W;
    assign is_stw   = fetch_valid_i && op10 == isa_pkg::OP_ST_W;
    assign is_stb   = fetch_valid_i && op10 == isa_pkg::OP_ST_B;
    assign is_lu12i = fetch_valid_i && op7 == isa_pkg::OP_LU12I_W;
    assign is_beq   = fetch_valid_i && op6 == isa_pkg::OP_BEQ;
    assign is_bne   = fetch_valid_i && op6 == isa_pkg::OP_BNE;
    assign is_b     = fetch_valid_i && op6 == isa_pkg::OP_B;

    assign is_rr  = is_add | is_sub | is_slt | is_and | is_or | is_xor;
    assign mem_op = is_ld | is_stw | is_stb;

    // second port reads rd for stores and compares
    assign rf.raddr1 = rj;
    assign rf.raddr2 = (is_stw | is_stb | is_beq | is_bne) ? rd : rk;

    always_comb begin
        if (is_sub) begin
            aluop_o = pipeline_types::ALU_SUB;
        end else if (is_slt) begin
            aluop_o = pipeline_types::ALU_SLT;
        end else if (is_and) begin
            aluop_o = pipeline_types::ALU_AND;
        end else if (is_or) begin
            aluop_o = pipeline_types::ALU_OR;
        end else if (is_xor) begin
            aluop_o = pipeline_types::ALU_XOR;
        end else if (is_lu12i) begin
            aluop_o = pipeline_types::ALU_LUI;
        end else begin
            aluop_o = pipeline_types::ALU_ADD;
        end
    end

    assign alu_a_o = rf.rdata1;
    always_comb begin
        if (is_rr) begin
            alu_b_o = rf.rdata2;
        end else if (is_lu12i) begin
            alu_b_o = {fetch_inst_i[24:5], 12'd0};
        end else begin
            alu_b_o = {{20{fetch_inst_i[21]}}, fetch_inst_i[21:10]};
        end
    end

    always_comb begin
        if (is_beq) begin
            br_kind_o = pipeline_types::BR_EQ;
        end else if (is_bne) begin
            br_kind_o = pipeline_types::BR_NE;
        end else if (is_b) begin
            br_kind_o = pipeline_types::BR_ALWAYS;
        end else begin
            br_kind_o = pipeline_types::BR_NONE;
        end
    end

    assign br_rj_o     = rf.rdata1;
    assign br_rd_o     = rf.rdata2;
    // offs26 keeps its high part in bits 9..0
    assign br_offset_o = is_b ? {{6{fetch_inst_i[9]}}, fetch_inst_i[9:0], fetch_inst_i[25:10]}
                              : {{16{fetch_inst_i[25]}}, fetch_inst_i[25:10]};

    // one lsu request per memory instruction
    always_ff @(posedge clk) begin
        if (rst_i) begin
            started_q <= 1'b0;
        end else if (lsu_done_i) begin
            started_q <= 1'b0;
        end else if (lsu_start_o) begin
            started_q <= 1'b1;
        end
    end

    assign lsu_start_o = mem_op & ~started_q;
    assign lsu_store_o = is_stw | is_stb;
    assign lsu_byte_o  = is_stb;
    assign lsu_addr_o  = alu_result_i;
    assign lsu_data_o  = rf.rdata2;

    assign stall_o    = mem_op & ~lsu_done_i;
    assign redirect_o = br_taken_i;
    assign target_o   = br_target_i;

    assign rf_we_o    = is_rr | is_addi | is_lu12i | (is_ld & lsu_done_i);
    assign rf_waddr_o = rd;
    assign rf_wdata_o = is_ld ? lsu_load_data_i : alu_result_i;

    a_no_redirect_in_stall: assert property (
        @(posedge clk) disable iff (rst_i)
        !(redirect_o && stall_o)
    );

endmodule

// ==== lsu.sv ====
`timescale 1ns/1ps

module lsu (
    input  logic                   clk,
    input  logic                   rst_i,
    input  logic                   start_i,
    input  logic                   store_i,
    input  logic                   byte_i,
    input  pipeline_types::bus32_t addr_i,
    input  pipeline_types::bus32_t data_i,
    input  logic                   cache_hit_i,
    input  pipeline_types::bus32_t ram_read_data_i,
    output pipeline_types::bus32_t ram_addr_o,
    output pipeline_types::bus32_t ram_write_data_o,
    output logic                   ram_write_en_o,
    output logic                   ram_read_en_o,
    output logic [3:0]             ram_select_o,
    output logic                   ram_en_o,
    output logic                   done_o,
    output pipeline_types::bus32_t load_data_o
);

    pipeline_types::lsu_state_t state_q;
    pipeline_types::bus32_t addr_q;
    pipeline_types::bus32_t wdata_q;
    logic [3:0] sel_q;
    logic store_q;
    logic busy;

    assign busy = (state_q == pipeline_types::LSU_BUSY);

    always_ff @(posedge clk) begin
        if (rst_i) begin
            state_q <= pipeline_types::LSU_IDLE;
        end else if (!busy && start_i) begin
            state_q <= pipeline_types::LSU_BUSY;
        end else if (busy && cache_hit_i) begin
            state_q <= pipeline_types::LSU_IDLE;
        end
    end

    always_ff @(posedge clk) begin
        if (!busy && start_i) begin
            addr_q  <= addr_i;
            store_q <= store_i;
            if (byte_i) begin
                // byte lane picked by low address bits
                sel_q   <= 4'b0001 << addr_i[1:0];
                wdata_q <= {4{data_i[7:0]}};
            end else begin
                sel_q   <= 4'b1111;
                wdata_q <= data_i;
            end
        end
    end

    // request held until the hit cycle
    assign ram_en_o         = busy;
    assign ram_write_en_o   = busy & store_q;
    assign ram_read_en_o    = busy & ~store_q;
    assign ram_addr_o       = addr_q;
    assign ram_write_data_o = wdata_q;
    assign ram_select_o     = sel_q;
    assign done_o           = busy & cache_hit_i;
    assign load_data_o      = ram_read_data_i;

    a_req_stable: assert property (
        @(posedge clk) disable iff (rst_i)
        (busy && !cache_hit_i) |=> (busy && $stable(addr_q) && $stable(wdata_q)
                                    && $stable(sel_q) && $stable(store_q))
    );

endmodule

// ==== branch_unit.sv ====
`timescale 1ns/1ps

module branch_unit (
    input  pipeline_types::br_kind_t kind_i,
    input  pipeline_types::bus32_t   pc_i,
    input  pipeline_types::bus32_t   rj_i,
    input  pipeline_types::bus32_t   rd_i,
    input  pipeline_types::bus32_t   offset_i,
    output logic                     taken_o,
    output pipeline_types::bus32_t   target_o
);

    always_comb begin
        case (kind_i)
            pipeline_types::BR_EQ:     taken_o = (rj_i == rd_i);
            pipeline_types::BR_NE:     taken_o = (rj_i != rd_i);
            pipeline_types::BR_ALWAYS: taken_o = 1'b1;
            default:                   taken_o = 1'b0;
        endcase
    end

    // offsets count words
    assign target_o = pc_i + {offset_i[29:0], 2'b00};

endmodule

// ==== alu.sv ====
`timescale 1ns/1ps

module alu (
    input  pipeline_types::aluop_t aluop_i,
    input  pipeline_types::bus32_t a_i,
    input  pipeline_types::bus32_t b_i,
    output pipeline_types::bus32_t result_o
);

    always_comb begin
        case (aluop_i)
            pipeline_types::ALU_ADD: result_o = a_i + b_i;
            pipeline_types::ALU_SUB: result_o = a_i - b_i;
            pipeline_types::ALU_SLT: begin
                result_o = {31'd0, $signed(a_i) < $signed(b_i)};
            end
            pipeline_types::ALU_AND: result_o = a_i & b_i;
            pipeline_types::ALU_OR:  result_o = a_i | b_i;
            pipeline_types::ALU_XOR: result_o = a_i ^ b_i;
            // immediate already shifted into place by decode
            pipeline_types::ALU_LUI: result_o = b_i;
            default:                 result_o = '0;
        endcase
    end

endmodule

// ==== pc.sv ====
`timescale 1ns/1ps
`include "cpu_cfg.svh"

module pc (
    input  logic                   clk,
    input  logic                   rst_i,
    input  logic                   stall_i,
    input  logic                   redirect_i,
    input  pipeline_types::bus32_t target_i,
    input  pipeline_types::bus32_t rom_inst_i,
    output pipeline_types::bus32_t pc_o,
    output logic                   inst_en_o,
    output logic                   fetch_valid_o,
    output pipeline_types::bus32_t fetch_pc_o,
    output pipeline_types::bus32_t fetch_inst_o
);

    pipeline_types::bus32_t pc_q;
    logic run_q;

    assign pc_o = pc_q;
    // fetch runs one cycle after reset release unless execute stalls
    assign inst_en_o = run_q & ~stall_i;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            pc_q          <= `CPU_RESET_PC;
            run_q         <= 1'b0;
            fetch_valid_o <= 1'b0;
        end else begin
            run_q <= 1'b1;
            if (redirect_i) begin
                // wrong-path word is dropped
                pc_q          <= target_i;
                fetch_valid_o <= 1'b0;
            end else if (inst_en_o) begin
                pc_q          <= pc_q + 32'd4;
                fetch_valid_o <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (inst_en_o && !redirect_i) begin
            fetch_pc_o   <= pc_q;
            fetch_inst_o <= rom_inst_i;
        end
    end

    a_no_fetch_in_reset: assert property (
        @(posedge clk) rst_i |=> !inst_en_o
    );

endmodule

// ==== regfile.sv ====
`timescale 1ns/1ps
`include "cpu_cfg.svh"

module regfile (
    input  logic                      clk,
    input  logic                      rst_i,
    regfile_if.file                   rd_port,
    input  logic                      we_i,
    input  pipeline_types::reg_addr_t waddr_i,
    input  pipeline_types::bus32_t    wdata_i
);

    pipeline_types::bus32_t regs [1 << `CPU_REG_ADDR_W];

    always_ff @(posedge clk) begin
        // r0 never takes a write
        if (rst_i) begin
            regs[0] <= '0;
        end else if (we_i && waddr_i != '0) begin
            regs[waddr_i] <= wdata_i;
        end
    end

    assign rd_port.rdata1 = regs[rd_port.raddr1];
    assign rd_port.rdata2 = regs[rd_port.raddr2];

    a_r0_zero: assert property (
        @(posedge clk) disable iff (rst_i)
        (rd_port.raddr1 == '0) |-> (rd_port.rdata1 == '0)
    );

endmodule

// ==== regfile_if.sv ====
`timescale 1ns/1ps

interface regfile_if;

    pipeline_types::reg_addr_t raddr1;
    pipeline_types::reg_addr_t raddr2;
    pipeline_types::bus32_t rdata1;
    pipeline_types::bus32_t rdata2;

    modport reader (
        output raddr1, raddr2,
        input  rdata1, rdata2
    );

    modport file (
        input  raddr1, raddr2,
        output rdata1, rdata2
    );

endinterface

// ==== pipeline_types.sv ====
`include "cpu_cfg.svh"

package pipeline_types;

    typedef logic [31:0] bus32_t;
    typedef logic [`CPU_REG_ADDR_W-1:0] reg_addr_t;

    typedef logic [2:0] aluop_t;

    localparam aluop_t ALU_ADD = 3'd0;
    localparam aluop_t ALU_SUB = 3'd1;
    localparam aluop_t ALU_SLT = 3'd2;
    localparam aluop_t ALU_AND = 3'd3;
    localparam aluop_t ALU_OR  = 3'd4;
    localparam aluop_t ALU_XOR = 3'd5;
    localparam aluop_t ALU_LUI = 3'd6;

    typedef logic [1:0] br_kind_t;

    localparam br_kind_t BR_NONE   = 2'd0;
    localparam br_kind_t BR_EQ     = 2'd1;
    localparam br_kind_t BR_NE     = 2'd2;
    localparam br_kind_t BR_ALWAYS = 2'd3;

    typedef enum logic {
        LSU_IDLE,
        LSU_BUSY
    } lsu_state_t;

endpackage

// ==== isa_pkg.sv ====
package isa_pkg;

    // three-register ops, opcode in bits 31..15
    localparam logic [16:0] OP_ADD_W = 17'h00020;
    localparam logic [16:0] OP_SUB_W = 17'h00022;
    localparam logic [16:0] OP_SLT   = 17'h00024;
    localparam logic [16:0] OP_AND   = 17'h00029;
    localparam logic [16:0] OP_OR    = 17'h0002a;
    localparam logic [16:0] OP_XOR   = 17'h0002b;

    // si12 forms, opcode in bits 31..22
    localparam logic [9:0] OP_ADDI_W = 10'h00a;
    localparam logic [9:0] OP_LD_W   = 10'h0a2;
    localparam logic [9:0] OP_ST_W   = 10'h0a6;
    localparam logic [9:0] OP_ST_B   = 10'h0a4;

    // si20 form, opcode in bits 31..25
    localparam logic [6:0] OP_LU12I_W = 7'h0a;

    // branches, opcode in bits 31..26
    localparam logic [5:0] OP_BEQ = 6'h16;
    localparam logic [5:0] OP_BNE = 6'h17;
    localparam logic [5:0] OP_B   = 6'h14;

    // register fields
    localparam int RD_LSB = 0;
    localparam int RJ_LSB = 5;
    localparam int RK_LSB = 10;

endpackage

// ==== cpu_cfg.svh ====
`ifndef CPU_CFG_SVH
`define CPU_CFG_SVH

// first fetch address after reset
`define CPU_RESET_PC 32'h1c00_0000

// 32 general registers
`define CPU_REG_ADDR_W 5

`endif
